/* cci_mpf_pkg.sv */
// ==========================================================================
// Shared widths, request and response structs and the Tx buffer threshold
// for the CCI request multiplexer. Modules import it inside their bodies
// and use scoped names in their port lists.
// ==========================================================================

`default_nettype none

package cci_mpf_pkg;

    // Number of client ports on the AFU side
    localparam int N_AFU_PORTS = 4;

    // Field widths
    localparam int PORT_IDX_BITS  = $clog2(N_AFU_PORTS);
    localparam int LINE_ADDR_BITS = 16;
    localparam int LINE_DATA_BITS = 32;
    localparam int MDATA_BITS     = 8;

    // The FIU-side tag is the port index placed above the client metadata
    localparam int FIU_MDATA_BITS = PORT_IDX_BITS + MDATA_BITS;

    // Almost-full rises when this many free slots or fewer remain
    localparam int TX_ALMOST_FULL_THRESHOLD = 4;

    typedef logic [PORT_IDX_BITS-1:0]  t_port_idx;
    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [LINE_DATA_BITS-1:0] t_line_data;
    typedef logic [MDATA_BITS-1:0]     t_mdata;
    typedef logic [FIU_MDATA_BITS-1:0] t_fiu_mdata;

    // ======================================================================
    // Tx requests
    // ======================================================================

    typedef struct packed {
        logic       valid;
        t_line_addr addr;
        t_mdata     mdata;
    } t_c0_tx;

    typedef struct packed {
        logic       valid;
        t_line_addr addr;
        t_line_data data;
        t_mdata     mdata;
    } t_c1_tx;

    typedef struct packed {
        logic       valid;
        t_line_addr addr;
        t_fiu_mdata mdata;
    } t_c0_tx_fiu;

    typedef struct packed {
        logic       valid;
        t_line_addr addr;
        t_line_data data;
        t_fiu_mdata mdata;
    } t_c1_tx_fiu;

    // One lockstep buffer entry, with c0 in the upper bits
    typedef struct packed {
        t_c0_tx c0;
        t_c1_tx c1;
    } t_lockstep_tx;

    // ======================================================================
    // Rx responses
    // ======================================================================

    typedef struct packed {
        logic       valid;
        t_line_data data;
        t_mdata     mdata;
    } t_c0_rx;

    typedef struct packed {
        logic   valid;
        t_mdata mdata;
    } t_c1_rx;

    typedef struct packed {
        logic       valid;
        t_line_data data;
        t_fiu_mdata mdata;
    } t_c0_rx_fiu;

    typedef struct packed {
        logic       valid;
        t_fiu_mdata mdata;
    } t_c1_rx_fiu;

endpackage

`default_nettype wire

/* cci_mpf_prim_fifo_lutram.sv */
// ==========================================================================
// Small FIFO in distributed RAM with a combinational head. The occupancy
// count drives not_empty and a registered almost_full level.
// ==========================================================================

`default_nettype none

module cci_mpf_prim_fifo_lutram
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 6,
    parameter int THRESHOLD   = 4
)
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    input  wire logic [N_DATA_BITS-1:0] enq_data,
    input  wire logic                   enq_en,

    output logic      [N_DATA_BITS-1:0] first,
    input  wire logic                   deq_en,

    output logic                        not_empty,
    output logic                        almost_full
);

    localparam int PTR_BITS = $clog2(N_ENTRIES);
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Entry storage, addressed by the read and write pointers
    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] count_next;
    logic                full;

    assign full      = (count == CNT_BITS'(N_ENTRIES));
    assign not_empty = (count != '0);

    // The head is read straight out of the array
    assign first = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Occupancy after this edge, used for both the count and almost_full
    always_comb
    begin
        count_next = count;
        if (enq_en && !deq_en)
        begin
            count_next = count + 1'b1;
        end
        else if (deq_en && !enq_en)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            // Pointers wrap at N_ENTRIES, which need not be a power of two
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;

            // Free slots at or below THRESHOLD raise the level
            almost_full <= (count_next >= CNT_BITS'(N_ENTRIES - THRESHOLD));
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> !full)
        else $error("FIFO enqueue while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("FIFO dequeue while empty");

endmodule

`default_nettype wire

/* cci_mpf_shim_buffer_lockstep_afu.sv */
// ==========================================================================
// Per-port Tx buffer that holds the c0 and c1 requests of one cycle as a
// single entry. Both channels leave together on one deq strobe.
// ==========================================================================

`default_nettype none

module cci_mpf_shim_buffer_lockstep_afu
(
    input  wire logic                        clk,
    input  wire logic                        reset,

    // Raw requests from the client
    input  wire cci_mpf_pkg::t_c0_tx         c0_tx,
    input  wire cci_mpf_pkg::t_c1_tx         c1_tx,

    // A single strobe moves both channels out of the buffer
    input  wire logic                        deq,
    output cci_mpf_pkg::t_lockstep_tx        head,

    output logic                             alm_full
);

    import cci_mpf_pkg::*;

    logic         enq_en;
    logic         not_empty;
    t_lockstep_tx enq_entry;
    t_lockstep_tx first;

    // A request exists when either channel carries a valid bit
    assign enq_en = c0_tx.valid || c1_tx.valid;

    // The struct fixes the field order on both sides of the FIFO
    assign enq_entry.c0 = c0_tx;
    assign enq_entry.c1 = c1_tx;

    // ======================================================================
    // Head of the buffer
    // ======================================================================

    always_comb
    begin
        head = first;

        // Stale array contents must not look like requests
        head.c0.valid = first.c0.valid && not_empty;
        head.c1.valid = first.c1.valid && not_empty;
    end

    // Depth leaves two slots beyond the almost-full threshold
    cci_mpf_prim_fifo_lutram
    #(
        .N_DATA_BITS ($bits(t_lockstep_tx)),
        .N_ENTRIES   (TX_ALMOST_FULL_THRESHOLD + 2),
        .THRESHOLD   (TX_ALMOST_FULL_THRESHOLD)
    )
    i_fifo
    (
        .clk,
        .reset,
        .enq_data    (enq_entry),
        .enq_en,
        .first,
        .deq_en      (deq),
        .not_empty,
        .almost_full (alm_full)
    );

    // The arbiter may only pull an entry that it saw as a request
    a_deq_has_request: assert property (@(posedge clk) disable iff (reset)
        deq |-> (head.c0.valid || head.c1.valid))
        else $error("Lockstep buffer dequeued without a valid head");

endmodule

`default_nettype wire

/* cci_mpf_rx_demux.sv */
// ==========================================================================
// Rx response demultiplexer. Registers each FIU response, strips the port
// tag and presents it on the owning port one cycle later.
// ==========================================================================

`default_nettype none

module cci_mpf_rx_demux
(
    input  wire logic                     clk,
    input  wire logic                     reset,

    input  wire cci_mpf_pkg::t_c0_rx_fiu  fiu_c0_rx,
    input  wire cci_mpf_pkg::t_c1_rx_fiu  fiu_c1_rx,

    output cci_mpf_pkg::t_c0_rx           c0_rx [cci_mpf_pkg::N_AFU_PORTS],
    output cci_mpf_pkg::t_c1_rx           c1_rx [cci_mpf_pkg::N_AFU_PORTS]
);

    import cci_mpf_pkg::*;

    // Port tags sit above the client metadata in the FIU tag
    t_port_idx c0_port;
    t_port_idx c1_port;

    assign c0_port = fiu_c0_rx.mdata[FIU_MDATA_BITS-1:MDATA_BITS];
    assign c1_port = fiu_c1_rx.mdata[FIU_MDATA_BITS-1:MDATA_BITS];

    // ======================================================================
    // Response registers
    // ======================================================================

    always_ff @(posedge clk)
    begin
        // Payload is broadcast to every port, only the valid bit selects
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            c0_rx[p].data  <= fiu_c0_rx.data;
            c0_rx[p].mdata <= fiu_c0_rx.mdata[MDATA_BITS-1:0];
            c1_rx[p].mdata <= fiu_c1_rx.mdata[MDATA_BITS-1:0];
        end

        if (reset)
        begin
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                c0_rx[p].valid <= 1'b0;
                c1_rx[p].valid <= 1'b0;
            end
        end
        else
        begin
            // The Rx side has no back-pressure, so a response is never held
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                c0_rx[p].valid <= fiu_c0_rx.valid && (c0_port == t_port_idx'(p));
                c1_rx[p].valid <= fiu_c1_rx.valid && (c1_port == t_port_idx'(p));
            end
        end
    end

endmodule

`default_nettype wire

/* cci_mpf_tx_arbiter.sv */
// ==========================================================================
// Round-robin Tx arbiter. Grants one buffer head per cycle, strobes its deq
// and registers the pair onto the FIU outputs with the port index as tag.
// ==========================================================================

`default_nettype none

module cci_mpf_tx_arbiter
(
    input  wire logic                          clk,
    input  wire logic                          reset,

    // Masked heads of the per-port lockstep buffers
    input  wire cci_mpf_pkg::t_lockstep_tx     heads [cci_mpf_pkg::N_AFU_PORTS],
    input  wire logic                          fiu_tx_alm_full,

    output logic [cci_mpf_pkg::N_AFU_PORTS-1:0] deq,

    output cci_mpf_pkg::t_c0_tx_fiu            fiu_c0_tx,
    output cci_mpf_pkg::t_c1_tx_fiu            fiu_c1_tx
);

    import cci_mpf_pkg::*;

    logic [N_AFU_PORTS-1:0] req;
    t_port_idx              last_grant;
    t_port_idx              cand;
    t_port_idx              grant_idx;
    logic                   grant_found;
    logic                   grant;

    // A head with either valid bit set is a request
    always_comb
    begin
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            req[p] = heads[p].c0.valid || heads[p].c1.valid;
        end
    end

    // ======================================================================
    // Grant selection
    // ======================================================================

    // Search starts one past the last winner and wraps around
    always_comb
    begin
        grant_found = 1'b0;
        grant_idx   = last_grant;
        cand        = last_grant;
        for (int i = 1; i <= N_AFU_PORTS; i++)
        begin
            cand = t_port_idx'((int'(last_grant) + i) % N_AFU_PORTS);
            if (!grant_found && req[cand])
            begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // The FIU stop level blocks any grant in this cycle
    assign grant = grant_found && !fiu_tx_alm_full;

    always_comb
    begin
        deq = '0;
        if (grant)
        begin
            deq[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        fiu_c0_tx.addr  <= heads[grant_idx].c0.addr;
        fiu_c0_tx.mdata <= {grant_idx, heads[grant_idx].c0.mdata};
        fiu_c1_tx.addr  <= heads[grant_idx].c1.addr;
        fiu_c1_tx.data  <= heads[grant_idx].c1.data;
        fiu_c1_tx.mdata <= {grant_idx, heads[grant_idx].c1.mdata};

        if (reset)
        begin
            fiu_c0_tx.valid <= 1'b0;
            fiu_c1_tx.valid <= 1'b0;
            // Port 0 wins first after reset
            last_grant      <= t_port_idx'(N_AFU_PORTS - 1);
        end
        else
        begin
            fiu_c0_tx.valid <= grant && heads[grant_idx].c0.valid;
            fiu_c1_tx.valid <= grant && heads[grant_idx].c1.valid;
            if (grant)
            begin
                last_grant <= grant_idx;
            end
        end
    end

    a_deq_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(deq))
        else $error("Arbiter dequeued more than one buffer");

endmodule

`default_nettype wire

/* cci_mpf_mux_top.sv */
// ==========================================================================
// Top of the CCI request multiplexer. Connects the Rx demux, one lockstep
// buffer per client port and the round-robin Tx arbiter.
// ==========================================================================

`default_nettype none

module cci_mpf_mux_top
(
    input  wire logic                           clk,
    input  wire logic                           reset,

    // AFU side, one entry per client port
    input  wire cci_mpf_pkg::t_c0_tx            afu_c0_tx [cci_mpf_pkg::N_AFU_PORTS],
    input  wire cci_mpf_pkg::t_c1_tx            afu_c1_tx [cci_mpf_pkg::N_AFU_PORTS],
    output logic [cci_mpf_pkg::N_AFU_PORTS-1:0] afu_tx_alm_full,
    output cci_mpf_pkg::t_c0_rx                 afu_c0_rx [cci_mpf_pkg::N_AFU_PORTS],
    output cci_mpf_pkg::t_c1_rx                 afu_c1_rx [cci_mpf_pkg::N_AFU_PORTS],

    // FIU side
    output cci_mpf_pkg::t_c0_tx_fiu             fiu_c0_tx,
    output cci_mpf_pkg::t_c1_tx_fiu             fiu_c1_tx,
    input  wire logic                           fiu_tx_alm_full,
    input  wire cci_mpf_pkg::t_c0_rx_fiu        fiu_c0_rx,
    input  wire cci_mpf_pkg::t_c1_rx_fiu        fiu_c1_rx
);

    import cci_mpf_pkg::*;

    logic [N_AFU_PORTS-1:0] deq;
    t_lockstep_tx           heads [N_AFU_PORTS];

    // Responses go straight back to their ports
    cci_mpf_rx_demux i_rx_demux
    (
        .clk,
        .reset,
        .fiu_c0_rx,
        .fiu_c1_rx,
        .c0_rx (afu_c0_rx),
        .c1_rx (afu_c1_rx)
    );

    // One lockstep buffer per client keeps its reads and writes in order
    for (genvar p = 0; p < N_AFU_PORTS; p++)
    begin : g_port
        cci_mpf_shim_buffer_lockstep_afu i_buffer
        (
            .clk,
            .reset,
            .c0_tx    (afu_c0_tx[p]),
            .c1_tx    (afu_c1_tx[p]),
            .deq      (deq[p]),
            .head     (heads[p]),
            .alm_full (afu_tx_alm_full[p])
        );
    end

    cci_mpf_tx_arbiter i_tx_arbiter
    (
        .clk,
        .reset,
        .heads,
        .fiu_tx_alm_full,
        .deq,
        .fiu_c0_tx,
        .fiu_c1_tx
    );

endmodule

`default_nettype wire

/* tb_cci_mpf_checker.sv */
// ==========================================================================
// Testbench checker for the CCI request multiplexer. Watches the DUT ports,
// models per-port request queues and buffer occupancy, and counts errors.
// ==========================================================================

`default_nettype none

module tb_cci_mpf_checker
(
    input  wire logic                            clk,
    input  wire logic                            reset,

    input  wire cci_mpf_pkg::t_c0_tx             afu_c0_tx [cci_mpf_pkg::N_AFU_PORTS],
    input  wire cci_mpf_pkg::t_c1_tx             afu_c1_tx [cci_mpf_pkg::N_AFU_PORTS],
    input  wire logic [cci_mpf_pkg::N_AFU_PORTS-1:0] afu_tx_alm_full,
    input  wire cci_mpf_pkg::t_c0_rx             afu_c0_rx [cci_mpf_pkg::N_AFU_PORTS],
    input  wire cci_mpf_pkg::t_c1_rx             afu_c1_rx [cci_mpf_pkg::N_AFU_PORTS],

    input  wire cci_mpf_pkg::t_c0_tx_fiu         fiu_c0_tx,
    input  wire cci_mpf_pkg::t_c1_tx_fiu         fiu_c1_tx,
    input  wire logic                            fiu_tx_alm_full,
    input  wire cci_mpf_pkg::t_c0_rx_fiu         fiu_c0_rx,
    input  wire cci_mpf_pkg::t_c1_rx_fiu         fiu_c1_rx,

    // High while all ports are backlogged and the FIU never stalls
    input  wire logic                            rr_check,

    output int                                   pending,
    output int                                   errors,
    output int                                   pairs_seen
);

    timeunit 1ns;
    timeprecision 1ps;

    import cci_mpf_pkg::*;

    // Expected FIU form of one accepted request pair
    typedef struct packed {
        t_c0_tx_fiu c0;
        t_c1_tx_fiu c1;
    } t_fiu_pair;

    t_fiu_pair              exp_q [N_AFU_PORTS][$];

    logic                   reset_d;
    logic                   reset_d2;
    logic                   stall_d;
    logic                   alm_chk;
    logic [N_AFU_PORTS-1:0] alm_exp;
    t_port_idx              rr_prev;
    logic                   rr_have_prev;
    t_c0_rx_fiu             rx0_d;
    t_c1_rx_fiu             rx1_d;

    initial
    begin
        reset_d      = 1'b0;
        reset_d2     = 1'b0;
        stall_d      = 1'b0;
        alm_chk      = 1'b0;
        rr_have_prev = 1'b0;
    end

    task automatic log_failure(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        errors++;
    endtask

    // The FIU tag is the port index followed by the client metadata
    function automatic t_fiu_pair to_fiu_pair(t_port_idx port, t_c0_tx c0, t_c1_tx c1);
        t_fiu_pair pair;
        pair.c0.valid = c0.valid;
        pair.c0.addr  = c0.addr;
        pair.c0.mdata = {port, c0.mdata};
        pair.c1.valid = c1.valid;
        pair.c1.addr  = c1.addr;
        pair.c1.data  = c1.data;
        pair.c1.mdata = {port, c1.mdata};
        return pair;
    endfunction

    // Fields of a channel without its valid bit carry no meaning
    function automatic bit pair_matches(t_fiu_pair exp_pair, t_c0_tx_fiu c0, t_c1_tx_fiu c1);
        bit ok;
        ok = (c0.valid == exp_pair.c0.valid) && (c1.valid == exp_pair.c1.valid);
        if (c0.valid && (c0.addr != exp_pair.c0.addr || c0.mdata != exp_pair.c0.mdata))
        begin
            ok = 1'b0;
        end
        if (c1.valid && (c1.addr != exp_pair.c1.addr || c1.data != exp_pair.c1.data ||
                         c1.mdata != exp_pair.c1.mdata))
        begin
            ok = 1'b0;
        end
        return ok;
    endfunction

    // ======================================================================
    // Comparison process, sampling everything on the rising edge
    // ======================================================================

    always @(posedge clk)
    begin : compare
        t_port_idx tag;
        t_fiu_pair exp_pair;
        logic      fiu_any;
        logic      exp_v0;
        logic      exp_v1;
        int        total;

        fiu_any = fiu_c0_tx.valid || fiu_c1_tx.valid;
        tag     = fiu_c0_tx.valid ? fiu_c0_tx.mdata[FIU_MDATA_BITS-1:MDATA_BITS]
                                  : fiu_c1_tx.mdata[FIU_MDATA_BITS-1:MDATA_BITS];

        if (reset_d || reset_d2)
        begin
            // Outputs set by a reset edge, and by the first edge after it
            if (fiu_c0_tx.valid !== 1'b0 || fiu_c1_tx.valid !== 1'b0)
                log_failure("FIU request valid during reset");
            if (afu_tx_alm_full !== '0)
                log_failure("AFU almost-full high during reset");
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                if (afu_c0_rx[p].valid !== 1'b0 || afu_c1_rx[p].valid !== 1'b0)
                    log_failure($sformatf("Rx valid on port %0d during reset", p));
            end
        end
        else
        begin
            // A stop level sampled at the last edge forbids any request now
            if (stall_d && fiu_any)
                log_failure("FIU request issued one cycle after a stall");

            if (fiu_any)
            begin
                if (fiu_c0_tx.valid && fiu_c1_tx.valid &&
                    fiu_c0_tx.mdata[FIU_MDATA_BITS-1:MDATA_BITS] !=
                    fiu_c1_tx.mdata[FIU_MDATA_BITS-1:MDATA_BITS])
                    log_failure("c0 and c1 of one FIU pair carry different port tags");

                if (exp_q[tag].size() == 0)
                begin
                    log_failure($sformatf("unexpected FIU request for port %0d", tag));
                end
                else
                begin
                    exp_pair = exp_q[tag].pop_front();
                    pairs_seen++;
                    if (!pair_matches(exp_pair, fiu_c0_tx, fiu_c1_tx))
                        log_failure($sformatf("port %0d FIU pair %h, expected %h",
                                              tag, {fiu_c0_tx, fiu_c1_tx}, exp_pair));
                end

                // Backlogged ports are served in strict circular order
                if (rr_check)
                begin
                    if (rr_have_prev && int'(tag) != (int'(rr_prev) + 1) % N_AFU_PORTS)
                        log_failure($sformatf("round-robin tag %0d after %0d", tag, rr_prev));
                    rr_prev      = tag;
                    rr_have_prev = 1'b1;
                end
            end

            // The buffer level reflects the occupancy after a stalled edge
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                if (alm_chk && afu_tx_alm_full[p] != alm_exp[p])
                    log_failure($sformatf("port %0d almost-full %0b, expected %0b",
                                          p, afu_tx_alm_full[p], alm_exp[p]));
            end

            // Each response shows up on its own port only, one cycle later
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                exp_v0 = rx0_d.valid && (rx0_d.mdata[FIU_MDATA_BITS-1:MDATA_BITS] == p);
                exp_v1 = rx1_d.valid && (rx1_d.mdata[FIU_MDATA_BITS-1:MDATA_BITS] == p);
                if (afu_c0_rx[p].valid != exp_v0)
                    log_failure($sformatf("port %0d c0 Rx valid %0b, expected %0b",
                                          p, afu_c0_rx[p].valid, exp_v0));
                else if (exp_v0 && (afu_c0_rx[p].data != rx0_d.data ||
                                    afu_c0_rx[p].mdata != rx0_d.mdata[MDATA_BITS-1:0]))
                    log_failure($sformatf("port %0d c0 Rx payload wrong", p));
                if (afu_c1_rx[p].valid != exp_v1)
                    log_failure($sformatf("port %0d c1 Rx valid %0b, expected %0b",
                                          p, afu_c1_rx[p].valid, exp_v1));
                else if (exp_v1 && afu_c1_rx[p].mdata != rx1_d.mdata[MDATA_BITS-1:0])
                    log_failure($sformatf("port %0d c1 Rx metadata wrong", p));
            end
        end

        // Every pair presented at an edge without reset is accepted by its buffer
        if (!reset)
        begin
            for (int p = 0; p < N_AFU_PORTS; p++)
            begin
                if (afu_c0_tx[p].valid || afu_c1_tx[p].valid)
                    exp_q[p].push_back(to_fiu_pair(t_port_idx'(p), afu_c0_tx[p], afu_c1_tx[p]));
            end
        end

        if (!rr_check)
            rr_have_prev = 1'b0;

        // With no grant at this edge the queue length equals the buffer count
        alm_chk = fiu_tx_alm_full && !reset;
        total   = 0;
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            alm_exp[p] = (exp_q[p].size() >= 2);
            total      = total + exp_q[p].size();
        end
        pending <= total;

        rx0_d    = fiu_c0_rx;
        rx1_d    = fiu_c1_rx;
        stall_d  = fiu_tx_alm_full && !reset;
        reset_d2 = reset_d;
        reset_d  = reset;
    end

endmodule

`default_nettype wire

/* tb_cci_mpf_mux.sv */
// ==========================================================================
// Testbench top for the CCI request multiplexer. Drives random AFU traffic,
// FIU stall bursts and tagged Rx responses, then a stalled fill and a
// round-robin drain. Comparison lives in the checker module.
// ==========================================================================

`default_nettype none

module tb_cci_mpf_mux;

    timeunit 1ns;
    timeprecision 1ps;

    import cci_mpf_pkg::*;

    localparam int     CLK_PERIOD     = 40;
    localparam int     N_RANDOM_REQS  = 60;
    localparam int     N_FILL_REQS    = TX_ALMOST_FULL_THRESHOLD + 2;
    localparam int     N_PLANNED_REQS = N_RANDOM_REQS + N_FILL_REQS;
    localparam int     DRAIN_LIMIT    = 400;
    localparam longint WATCHDOG_NS    =
        longint'(N_PLANNED_REQS * N_AFU_PORTS * 10 + 500) * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    t_c0_tx                 afu_c0_tx [N_AFU_PORTS];
    t_c1_tx                 afu_c1_tx [N_AFU_PORTS];
    logic [N_AFU_PORTS-1:0] afu_tx_alm_full;
    t_c0_rx                 afu_c0_rx [N_AFU_PORTS];
    t_c1_rx                 afu_c1_rx [N_AFU_PORTS];
    t_c0_tx_fiu             fiu_c0_tx;
    t_c1_tx_fiu             fiu_c1_tx;
    logic                   fiu_tx_alm_full;
    t_c0_rx_fiu             fiu_c0_rx;
    t_c1_rx_fiu             fiu_c1_rx;

    logic                   rr_check;
    int                     pending;
    int                     chk_errors;
    int                     pairs_seen;
    int                     drain_errors;
    int                     issued [N_AFU_PORTS];
    int                     stall_left;
    integer                 seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cci_mpf_mux_top i_cci_mpf_mux_top
    (
        .clk, .reset,
        .afu_c0_tx, .afu_c1_tx, .afu_tx_alm_full, .afu_c0_rx, .afu_c1_rx,
        .fiu_c0_tx, .fiu_c1_tx, .fiu_tx_alm_full, .fiu_c0_rx, .fiu_c1_rx
    );

    tb_cci_mpf_checker i_checker
    (
        .clk, .reset,
        .afu_c0_tx, .afu_c1_tx, .afu_tx_alm_full, .afu_c0_rx, .afu_c1_rx,
        .fiu_c0_tx, .fiu_c1_tx, .fiu_tx_alm_full, .fiu_c0_rx, .fiu_c1_rx,
        .rr_check,
        .pending,
        .errors     (chk_errors),
        .pairs_seen
    );

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    task automatic clear_inputs();
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            afu_c0_tx[p] <= '0;
            afu_c1_tx[p] <= '0;
        end
        fiu_c0_rx <= '0;
        fiu_c1_rx <= '0;
    endtask

    // Kind 0 is a read only, 1 a write only and 2 a read and write pair
    task automatic issue_request(input int p);
        int     kind;
        t_c0_tx c0;
        t_c1_tx c1;
        kind     = {$random(seed)} % 3;
        c0.addr  = $random(seed);
        c0.mdata = $random(seed);
        c1.addr  = $random(seed);
        c1.data  = $random(seed);
        c1.mdata = $random(seed);
        c0.valid = (kind != 1);
        c1.valid = (kind != 0);
        afu_c0_tx[p] <= c0;
        afu_c1_tx[p] <= c1;
        issued[p]++;
    endtask

    task automatic drive_random_cycle();
        t_c0_rx_fiu rx0;
        t_c1_rx_fiu rx1;
        // Clients hold off while their buffer reports almost full
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            if (issued[p] < N_RANDOM_REQS && !afu_tx_alm_full[p] && $random(seed) % 2 != 0)
            begin
                issue_request(p);
            end
            else
            begin
                afu_c0_tx[p] <= '0;
                afu_c1_tx[p] <= '0;
            end
        end

        // FIU stalls arrive as bursts of one to six cycles
        if (stall_left > 0)
        begin
            fiu_tx_alm_full <= 1'b1;
            stall_left--;
        end
        else
        begin
            fiu_tx_alm_full <= 1'b0;
            if ({$random(seed)} % 10 == 0)
                stall_left = 1 + {$random(seed)} % 6;
        end

        // Responses carry a random port tag in the upper metadata bits
        rx0.valid = $random(seed) % 2 != 0;
        rx0.data  = $random(seed);
        rx0.mdata = $random(seed);
        rx1.valid = $random(seed) % 2 != 0;
        rx1.mdata = $random(seed);
        fiu_c0_rx <= rx0;
        fiu_c1_rx <= rx1;
    endtask

    function automatic bit all_issued();
        for (int p = 0; p < N_AFU_PORTS; p++)
        begin
            if (issued[p] < N_RANDOM_REQS)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // The pending count lags the inputs, hence the two leading edges
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        repeat (2) @(posedge clk);
        while (pending != 0 && cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (pending != 0)
        begin
            $display("Error: %0d requests still pending after %0d drain cycles",
                     pending, DRAIN_LIMIT);
            drain_errors++;
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        seed            = 92475;
        clk             = 1'b0;
        reset           = 1'b1;
        rr_check        = 1'b0;
        fiu_tx_alm_full = 1'b0;
        stall_left      = 0;
        drain_errors    = 0;
        for (int p = 0; p < N_AFU_PORTS; p++)
            issued[p] = 0;
        clear_inputs();

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Random mixed traffic with stall bursts and Rx responses
        while (!all_issued())
        begin
            @(posedge clk);
            drive_random_cycle();
        end
        @(posedge clk);
        clear_inputs();
        fiu_tx_alm_full <= 1'b0;
        wait_drain();

        // Stalled fill from empty, two requests plus the four allowed after
        @(posedge clk);
        fiu_tx_alm_full <= 1'b1;
        repeat (N_FILL_REQS)
        begin
            @(posedge clk);
            for (int p = 0; p < N_AFU_PORTS; p++)
                issue_request(p);
        end
        @(posedge clk);
        clear_inputs();

        // Release the FIU while every port is backlogged
        @(posedge clk);
        fiu_tx_alm_full <= 1'b0;
        rr_check        <= 1'b1;
        wait_drain();
        @(posedge clk);
        rr_check <= 1'b0;
        repeat (4) @(posedge clk);

        @(negedge clk);
        $display("Errors: %0d from checks, %0d from drain; FIU pairs checked: %0d",
                 chk_errors, drain_errors, pairs_seen);
        if (chk_errors + drain_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog sized from the planned request count
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
cci_mpf_pkg.sv
cci_mpf_prim_fifo_lutram.sv
cci_mpf_shim_buffer_lockstep_afu.sv
cci_mpf_rx_demux.sv
cci_mpf_tx_arbiter.sv
cci_mpf_mux_top.sv
tb_cci_mpf_checker.sv
tb_cci_mpf_mux.sv

/* Bender.yml */
package:
  name: cci_mpf_mux

sources:
  - cci_mpf_pkg.sv
  - cci_mpf_prim_fifo_lutram.sv
  - cci_mpf_shim_buffer_lockstep_afu.sv
  - cci_mpf_rx_demux.sv
  - cci_mpf_tx_arbiter.sv
  - cci_mpf_mux_top.sv
  - target: test
    files:
      - tb_cci_mpf_checker.sv
      - tb_cci_mpf_mux.sv
